// ==== design/serializer_pkg.sv ====
package serializer_pkg;

   // worker threads and ready-list depth
   localparam int N_THREADS   = 8;
   localparam int LOG_THREADS = $clog2(N_THREADS);
   localparam int LOG_SLOTS   = 3;
   localparam int N_SLOTS     = 2**LOG_SLOTS;

   localparam int OBJECT_WIDTH = 16;
   localparam int TS_WIDTH     = 32;
   localparam int TTYPE_WIDTH  = 4;

   typedef logic [OBJECT_WIDTH-1:0] object_t;

   typedef struct packed {
      logic [TS_WIDTH-1:0]    ts;
      object_t                object;
      logic [TTYPE_WIDTH-1:0] ttype;
   } task_t;

   // slot number inside the upstream task queue
   typedef logic [6:0] cq_slot_t;

   typedef logic [LOG_THREADS-1:0] thread_id_t;

   // ready-list position, also used as payload index
   typedef logic [LOG_SLOTS-1:0] slot_id_t;

endpackage

// ==== design/ready_list_if.sv ====
`timescale 1ns/1ps

interface ready_list_if import serializer_pkg::*; ();

   // insert broadcast from the enqueue side
   logic     enq_valid;
   slot_id_t enq_loc;
   object_t  enq_object;
   slot_id_t enq_idx;
   logic     enq_conflict;

   // issue and unlock broadcasts
   logic     issue_valid;
   slot_id_t issue_sel;
   logic     clear_valid;
   slot_id_t clear_sel;
   logic     unlock_valid;
   object_t  unlock_object;

   // one element per list position, each driven by its own slot
   logic     valid    [N_SLOTS];
   logic     conflict [N_SLOTS];
   object_t  object   [N_SLOTS];
   slot_id_t idx      [N_SLOTS];
   logic     match    [N_SLOTS];

   modport enq (
      output enq_valid, enq_loc, enq_object, enq_idx, enq_conflict,
      input  issue_valid, issue_sel, valid, object, idx
   );

   modport issue (
      output issue_valid, issue_sel, clear_valid, clear_sel, unlock_valid, unlock_object,
      input  valid, conflict, object, match
   );

   modport slot (
      input  enq_valid, enq_loc, enq_object, enq_idx, enq_conflict,
      input  issue_valid, issue_sel, clear_valid, clear_sel, unlock_valid, unlock_object,
      output valid, conflict, object, idx, match
   );

endinterface

// ==== design/id_free_list.sv ====
`timescale 1ns/1ps

module id_free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic                 pop,
   input  logic [LOG_DEPTH-1:0] push_id,
   output logic [LOG_DEPTH-1:0] head_id,
   output logic                 empty,
   output logic [LOG_DEPTH:0]   count
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ids [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;

   // after reset every id is free, stored in ascending order
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (LOG_DEPTH+1)'(DEPTH);
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= LOG_DEPTH'(i);
         end
      end else begin
         if (push) begin
            ids[wr_ptr] <= push_id;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // a push and a pop together leave the fill unchanged
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign head_id = ids[rd_ptr];
   assign empty   = (count == '0);

endmodule

// ==== design/task_store.sv ====
`timescale 1ns/1ps

module task_store import serializer_pkg::*; (
   input  logic     clk,
   input  logic     wr,
   input  slot_id_t wr_idx,
   input  task_t    wr_task,
   input  cq_slot_t wr_slot,
   input  slot_id_t rd_idx,
   output task_t    rd_task,
   output cq_slot_t rd_slot
);

   task_t    task_mem [N_SLOTS];
   cq_slot_t slot_mem [N_SLOTS];

   always_ff @(posedge clk) begin
      if (wr) begin
         task_mem[wr_idx] <= wr_task;
         slot_mem[wr_idx] <= wr_slot;
      end
   end

   // read is combinational so the offered task follows issue_sel directly
   assign rd_task = task_mem[rd_idx];
   assign rd_slot = slot_mem[rd_idx];

endmodule

// ==== design/enq_ctrl.sv ====
`timescale 1ns/1ps

module enq_ctrl import serializer_pkg::*; #(
   parameter int ALMOST_FULL_THRESHOLD = N_SLOTS - 4,
   parameter int FULL_THRESHOLD        = N_SLOTS - 1
) (
   input  logic     clk,
   input  logic     rstn,
   input  task_t    m_task,
   input  cq_slot_t m_cq_slot,
   input  logic     m_valid,
   output logic     m_ready,
   input  logic     running_hit,
   output logic     almost_full,
   output task_t    s_rdata,
   output cq_slot_t s_cq_slot,
   ready_list_if.enq rl
);

   slot_id_t           insert_loc;
   logic               slot_free;
   logic               list_hit;
   slot_id_t           free_idx;
   logic               idx_empty;
   logic [LOG_SLOTS:0] idx_count;
   logic [LOG_SLOTS:0] occupancy;
   logic               accept;
   slot_id_t           issued_idx;

   // lowest free position, and whether a queued entry holds the same object
   always_comb begin
      insert_loc = '0;
      slot_free  = 1'b0;
      list_hit   = 1'b0;
      for (int i = N_SLOTS-1; i >= 0; i--) begin
         if (!rl.valid[i]) begin
            insert_loc = slot_id_t'(i);
            slot_free  = 1'b1;
         end
         if (rl.valid[i] && (rl.object[i] == m_task.object)) begin
            list_hit = 1'b1;
         end
      end
   end

   // every queued task holds one payload index
   assign occupancy   = (LOG_SLOTS+1)'(N_SLOTS) - idx_count;
   assign almost_full = (occupancy >= ALMOST_FULL_THRESHOLD);

   assign m_ready = m_valid && slot_free && !idx_empty && (occupancy <= FULL_THRESHOLD);
   assign accept  = m_valid && m_ready;

   assign rl.enq_valid    = accept;
   assign rl.enq_loc      = insert_loc;
   assign rl.enq_object   = m_task.object;
   assign rl.enq_idx      = free_idx;
   assign rl.enq_conflict = list_hit || running_hit;

   assign issued_idx = rl.idx[rl.issue_sel];

   id_free_list #(
      .LOG_DEPTH(LOG_SLOTS)
   ) u_idx_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (rl.issue_valid),
      .pop     (accept),
      .push_id (issued_idx),
      .head_id (free_idx),
      .empty   (idx_empty),
      .count   (idx_count)
   );

   task_store u_store (
      .clk     (clk),
      .wr      (accept),
      .wr_idx  (free_idx),
      .wr_task (m_task),
      .wr_slot (m_cq_slot),
      .rd_idx  (issued_idx),
      .rd_task (s_rdata),
      .rd_slot (s_cq_slot)
   );

endmodule

// ==== design/ready_slot.sv ====
`timescale 1ns/1ps

module ready_slot import serializer_pkg::*; #(
   parameter int SLOT_IDX = 0
) (
   input logic clk,
   input logic rstn,
   ready_list_if.slot rl
);

   localparam bit TOP = (SLOT_IDX == N_SLOTS-1);
   localparam int UP  = TOP ? SLOT_IDX : SLOT_IDX + 1;

   logic     valid_q;
   logic     conflict_q;
   object_t  object_q;
   slot_id_t idx_q;

   logic     shift;
   logic     ins_above;
   logic     ins_here;
   logic     clr_above;
   logic     clr_here;
   logic     up_valid;
   logic     up_conflict;
   object_t  up_object;
   slot_id_t up_idx;

   // an issue at or below this position moves everything above down by one
   assign shift     = rl.issue_valid && (SLOT_IDX >= rl.issue_sel);
   assign ins_above = rl.enq_valid && (rl.enq_loc == SLOT_IDX + 1);
   assign ins_here  = rl.enq_valid && (rl.enq_loc == SLOT_IDX);
   assign clr_above = rl.clear_valid && (rl.clear_sel == SLOT_IDX + 1);
   assign clr_here  = rl.clear_valid && (rl.clear_sel == SLOT_IDX);

   // the top slot shifts in an empty entry
   assign up_valid    = TOP ? 1'b0 : rl.valid[UP];
   assign up_conflict = TOP ? 1'b0 : rl.conflict[UP];
   assign up_object   = TOP ? '0 : rl.object[UP];
   assign up_idx      = TOP ? '0 : rl.idx[UP];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         valid_q    <= 1'b0;
         conflict_q <= 1'b0;
      end else if (shift) begin
         if (ins_above) begin
            valid_q    <= 1'b1;
            conflict_q <= rl.enq_conflict;
         end else begin
            valid_q    <= up_valid;
            conflict_q <= up_conflict && !clr_above;
         end
      end else if (ins_here) begin
         valid_q    <= 1'b1;
         conflict_q <= rl.enq_conflict;
      end else if (clr_here) begin
         conflict_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (shift) begin
         object_q <= ins_above ? rl.enq_object : up_object;
         idx_q    <= ins_above ? rl.enq_idx : up_idx;
      end else if (ins_here) begin
         object_q <= rl.enq_object;
         idx_q    <= rl.enq_idx;
      end
   end

   assign rl.valid[SLOT_IDX]    = valid_q;
   assign rl.conflict[SLOT_IDX] = conflict_q;
   assign rl.object[SLOT_IDX]   = object_q;
   assign rl.idx[SLOT_IDX]      = idx_q;
   assign rl.match[SLOT_IDX]    = rl.unlock_valid && valid_q && (object_q == rl.unlock_object);

endmodule

// ==== design/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl import serializer_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   output logic       s_valid,
   input  logic       s_ready,
   output thread_id_t s_thread,
   input  logic       unlock_valid,
   input  thread_id_t unlock_thread,
   input  object_t    m_object,
   output logic       running_hit,
   output logic       all_cores_idle,
   ready_list_if.issue rl
);

   object_t              run_obj [N_THREADS];
   logic [N_THREADS-1:0] run_valid;

   slot_id_t             issue_sel;
   logic                 any_ready;
   slot_id_t             clear_sel;
   logic                 any_match;
   logic                 list_empty;
   logic                 thread_empty;
   logic                 issue;

   // oldest ready entry, oldest entry matching the unlock, and list occupancy
   always_comb begin
      issue_sel  = '0;
      any_ready  = 1'b0;
      clear_sel  = '0;
      any_match  = 1'b0;
      list_empty = 1'b1;
      for (int i = N_SLOTS-1; i >= 0; i--) begin
         if (rl.valid[i] && !rl.conflict[i]) begin
            issue_sel = slot_id_t'(i);
            any_ready = 1'b1;
         end
         if (rl.match[i]) begin
            clear_sel = slot_id_t'(i);
            any_match = 1'b1;
         end
         if (rl.valid[i]) begin
            list_empty = 1'b0;
         end
      end
   end

   assign s_valid = any_ready && !thread_empty;
   assign issue   = s_valid && s_ready;

   assign rl.issue_valid   = issue;
   assign rl.issue_sel     = issue_sel;
   assign rl.clear_valid   = any_match;
   assign rl.clear_sel     = clear_sel;
   assign rl.unlock_valid  = unlock_valid;
   assign rl.unlock_object = run_obj[unlock_thread];

   // the unlocking thread no longer counts as holding its object
   always_comb begin
      running_hit = 1'b0;
      for (int t = 0; t < N_THREADS; t++) begin
         if (run_valid[t] && (run_obj[t] == m_object) &&
             !(unlock_valid && (unlock_thread == thread_id_t'(t)))) begin
            running_hit = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_valid <= '0;
      end else begin
         if (unlock_valid) begin
            run_valid[unlock_thread] <= 1'b0;
         end
         if (issue) begin
            run_valid[s_thread] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         run_obj[s_thread] <= rl.object[issue_sel];
      end
   end

   assign all_cores_idle = list_empty && (run_valid == '0);

   id_free_list #(
      .LOG_DEPTH(LOG_THREADS)
   ) u_thread_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (unlock_valid),
      .pop     (issue),
      .push_id (unlock_thread),
      .head_id (s_thread),
      .empty   (thread_empty),
      .count   ()
   );

endmodule

// ==== design/conflict_serializer.sv ====
`timescale 1ns/1ps

module conflict_serializer import serializer_pkg::*; #(
   parameter int ALMOST_FULL_THRESHOLD = N_SLOTS - 4,
   parameter int FULL_THRESHOLD        = N_SLOTS - 1
) (
   input  logic       clk,
   input  logic       rstn,

   // issue to the worker threads
   output logic       s_valid,
   input  logic       s_ready,
   output task_t      s_rdata,
   output cq_slot_t   s_cq_slot,
   output thread_id_t s_thread,

   input  logic       unlock_valid,
   input  thread_id_t unlock_thread,

   // enqueue from the task queue
   input  task_t      m_task,
   input  cq_slot_t   m_cq_slot,
   input  logic       m_valid,
   output logic       m_ready,

   output logic       almost_full,
   output logic       all_cores_idle
);

   logic running_hit;

   ready_list_if rl ();

   enq_ctrl #(
      .ALMOST_FULL_THRESHOLD (ALMOST_FULL_THRESHOLD),
      .FULL_THRESHOLD        (FULL_THRESHOLD)
   ) u_enq (
      .clk         (clk),
      .rstn        (rstn),
      .m_task      (m_task),
      .m_cq_slot   (m_cq_slot),
      .m_valid     (m_valid),
      .m_ready     (m_ready),
      .running_hit (running_hit),
      .almost_full (almost_full),
      .s_rdata     (s_rdata),
      .s_cq_slot   (s_cq_slot),
      .rl          (rl)
   );

   issue_ctrl u_issue (
      .clk            (clk),
      .rstn           (rstn),
      .s_valid        (s_valid),
      .s_ready        (s_ready),
      .s_thread       (s_thread),
      .unlock_valid   (unlock_valid),
      .unlock_thread  (unlock_thread),
      .m_object       (m_task.object),
      .running_hit    (running_hit),
      .all_cores_idle (all_cores_idle),
      .rl             (rl)
   );

   // position 0 holds the oldest task
   for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
      ready_slot #(
         .SLOT_IDX(i)
      ) u_slot (
         .clk  (clk),
         .rstn (rstn),
         .rl   (rl)
      );
   end

endmodule

// ==== verif/conflict_serializer_tb.sv ====
`timescale 1ns/1ps

module conflict_serializer_tb import serializer_pkg::*; ();

   localparam int CLK_PERIOD  = 100;
   localparam int STIM_CYCLES = 3000;
   localparam int AF_LEVEL    = N_SLOTS - 4;
   localparam int FULL_LEVEL  = N_SLOTS - 1;
   localparam int N_OBJECTS   = 4;

   logic       clk = 1'b0;
   logic       rstn;
   logic       s_valid;
   logic       s_ready;
   task_t      s_rdata;
   cq_slot_t   s_cq_slot;
   thread_id_t s_thread;
   logic       unlock_valid;
   thread_id_t unlock_thread;
   task_t      m_task;
   cq_slot_t   m_cq_slot;
   logic       m_valid;
   logic       m_ready;
   logic       almost_full;
   logic       all_cores_idle;

   // reference model: accepted tasks in order, running objects, occupancy
   task_t       acc_task [$];
   cq_slot_t    acc_slot [$];
   logic        busy    [N_THREADS] = '{default: 1'b0};
   object_t     run_obj [N_THREADS] = '{default: '0};
   int          hold    [N_THREADS] = '{default: 0};
   int          occ     = 0;
   int          cycle   = 0;
   int          errors  = 0;
   int          issued  = 0;
   logic        drained = 1'b0;
   logic [31:0] rng     = 32'd40;
   logic [31:0] ts_next = '0;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] expv,
                                  input logic [63:0] gotv);
      $display("mismatch at time %0t: %s expected %h got %h", $time, name, expv, gotv);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("error at time %0t: %s", $time, msg);
      errors++;
   endtask

   always #(CLK_PERIOD/2) clk = ~clk;

   conflict_serializer #(
      .ALMOST_FULL_THRESHOLD (AF_LEVEL),
      .FULL_THRESHOLD        (FULL_LEVEL)
   ) uut (
      .clk            (clk),
      .rstn           (rstn),
      .s_valid        (s_valid),
      .s_ready        (s_ready),
      .s_rdata        (s_rdata),
      .s_cq_slot      (s_cq_slot),
      .s_thread       (s_thread),
      .unlock_valid   (unlock_valid),
      .unlock_thread  (unlock_thread),
      .m_task         (m_task),
      .m_cq_slot      (m_cq_slot),
      .m_valid        (m_valid),
      .m_ready        (m_ready),
      .almost_full    (almost_full),
      .all_cores_idle (all_cores_idle)
   );

   // samples the pre-edge state, updates the model, then drives the next inputs
   always @(posedge clk) begin : model
      task_t nt;
      logic  found;
      int    pos;
      int    busy_cnt;
      if (rstn) begin
         busy_cnt = 0;
         for (int t = 0; t < N_THREADS; t++) begin
            if (busy[t]) begin
               busy_cnt++;
            end
         end
         if (cycle == 0) begin
            assert (!s_valid && !m_ready && !almost_full && all_cores_idle)
               else report_failure("outputs are not at their values after reset");
         end
         assert (almost_full == (occ >= AF_LEVEL))
            else report_mismatch("almost_full", 64'(occ >= AF_LEVEL), 64'(almost_full));
         assert (!(m_ready && occ > FULL_LEVEL))
            else report_failure("m_ready is high while occupancy is above the full level");
         // below the full level a slot is always free for the offer
         assert (!(m_valid && !m_ready && occ <= FULL_LEVEL))
            else report_failure("m_ready is low although the list has room for the offer");
         assert (!(m_ready && !m_valid))
            else report_failure("m_ready is high while m_valid is low");
         assert (all_cores_idle == (occ == 0 && busy_cnt == 0))
            else report_mismatch("all_cores_idle", 64'(occ == 0 && busy_cnt == 0),
                                 64'(all_cores_idle));
         assert (!(s_valid && occ == 0))
            else report_failure("s_valid is high while the list is empty");
         drained = (cycle > STIM_CYCLES) && !m_valid && !unlock_valid && (occ == 0) &&
                   (busy_cnt == 0) && all_cores_idle;

         if (s_valid && s_ready) begin
            assert (!busy[s_thread])
               else report_failure("task issued to a thread that is still running");
            for (int t = 0; t < N_THREADS; t++) begin
               assert (!(busy[t] && run_obj[t] == s_rdata.object))
                  else report_failure("issued object is held by a running thread");
            end
            // the head of this object's queue is its oldest accepted task
            found = 1'b0;
            pos   = 0;
            for (int i = 0; i < acc_task.size(); i++) begin
               if (!found && acc_task[i].object == s_rdata.object) begin
                  found = 1'b1;
                  pos   = i;
               end
            end
            if (found) begin
               assert (s_rdata == acc_task[pos])
                  else report_mismatch("s_rdata", 64'(acc_task[pos]), 64'(s_rdata));
               assert (s_cq_slot == acc_slot[pos])
                  else report_mismatch("s_cq_slot", 64'(acc_slot[pos]), 64'(s_cq_slot));
               acc_task.delete(pos);
               acc_slot.delete(pos);
               occ--;
            end else begin
               report_failure("issued task was never accepted");
            end
            issued++;
         end

         if (unlock_valid) begin
            busy[unlock_thread] = 1'b0;
         end
         if (s_valid && s_ready) begin
            busy[s_thread]    = 1'b1;
            run_obj[s_thread] = s_rdata.object;
            rng               = xorshift(rng);
            hold[s_thread]    = 1 + int'(rng % 8);
         end
         if (m_valid && m_ready) begin
            acc_task.push_back(m_task);
            acc_slot.push_back(m_cq_slot);
            occ++;
         end

         // thread model: one unlock per cycle, lowest expired thread first
         found = 1'b0;
         unlock_valid <= 1'b0;
         for (int t = 0; t < N_THREADS; t++) begin
            if (busy[t] && hold[t] > 0) begin
               hold[t]--;
            end
            if (!found && busy[t] && hold[t] == 0) begin
               found = 1'b1;
               unlock_valid  <= 1'b1;
               unlock_thread <= thread_id_t'(t);
            end
         end

         rng = xorshift(rng);
         s_ready <= (cycle < STIM_CYCLES) ? (rng[3:0] < 4'd11) : 1'b1;
         // a pending offer is held until it is accepted
         if (!m_valid || m_ready) begin
            rng = xorshift(rng);
            if (cycle < STIM_CYCLES && rng[3:0] < 4'd10) begin
               nt.ts     = ts_next;
               nt.object = object_t'(32'h100 + (rng[7:4] % N_OBJECTS));
               nt.ttype  = rng[11:8];
               ts_next   = ts_next + 1;
               m_task    <= nt;
               m_cq_slot <= rng[18:12];
               m_valid   <= 1'b1;
            end else begin
               m_valid <= 1'b0;
            end
         end
         cycle++;
      end
   end

   initial begin
      rstn          = 1'b0;
      s_ready       = 1'b0;
      unlock_valid  = 1'b0;
      unlock_thread = '0;
      m_task        = '0;
      m_cq_slot     = '0;
      m_valid       = 1'b0;
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      wait (drained);
      repeat (4) @(posedge clk);
      if (issued == 0) begin
         report_failure("no task was issued");
      end
      $display("errors: %0d, tasks issued: %0d", errors, issued);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(20 * STIM_CYCLES * CLK_PERIOD);
      report_failure("timeout, the list did not drain");
      $display("errors: %0d, tasks issued: %0d", errors, issued);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== conflict_serializer.f ====
design/serializer_pkg.sv
design/ready_list_if.sv
design/id_free_list.sv
design/task_store.sv
design/enq_ctrl.sv
design/ready_slot.sv
design/issue_ctrl.sv
design/conflict_serializer.sv
verif/conflict_serializer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conflict serializer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f conflict_serializer.f \
   --top-module conflict_serializer_tb -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
   exit 0
fi
exit 1
